// ==== tb/divsqrt_stimulus.txt ====
# kind op fmt a b result div_zero, all hex; op 0 div 1 sqrt, fmt 0 W32 1 W16
# kind 0 plain, 1 extra start while busy, 2 killed op before this one
0 0 0 00000064 00000007 0000000e 0
0 0 0 ffffffff 00000001 ffffffff 0
0 0 0 ffffffff ffffffff 00000001 0
0 0 0 80000000 00010000 00008000 0
0 0 0 12345678 00001000 00012345 0
0 0 0 00000005 00000009 00000000 0
0 0 0 deadbeef 000000ff 00df8d4c 0
0 0 0 00001234 00000000 ffffffff 1
0 0 0 00000100 00000010 00000010 0
0 0 1 abcd1000 ffff0010 ffff0100 0
0 0 1 0000ffff 00000003 ffff5555 0
0 0 1 00000042 00010000 ffffffff 1
0 1 0 00000000 00000000 00000000 0
0 1 0 00000051 00000000 00000009 0
0 1 0 ffffffff 00000000 0000ffff 0
0 1 0 000003e7 00000000 0000001f 0
0 1 0 12345678 00000000 00004444 0
0 1 1 dead0090 00000000 ffff000c 0
0 1 1 0000ffff 00000000 ffff00ff 0
1 0 0 ffffffff 00000010 0fffffff 0
2 0 0 000003e8 00000019 00000028 0

// ==== sources.f ====
+incdir+hdl
hdl/divsqrt_pkg.sv
hdl/wb_pkg.sv
hdl/divsqrt_wb_regs.sv
hdl/divsqrt_fsm.sv
hdl/iter_counter.sv
hdl/divsqrt_datapath.sv
hdl/divsqrt_top.sv
tb/divsqrt_checker.sv
tb/tb_divsqrt.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_divsqrt -f sources.f -Mdir obj_dir
./obj_dir/Vtb_divsqrt | tee sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tb/tb_divsqrt.sv ====
// Divide and square-root unit testbench

`timescale 1ns/10ps
`include "divsqrt_params.svh"

module tb_divsqrt;

  import wb_pkg::*;
  import divsqrt_pkg::*;

  localparam int ACK_LIMIT  = 16;  // Cycles to wait for ack
  localparam int POLL_LIMIT = 64;  // STATUS reads before giving up
  localparam logic [`DS_DATA_W-1:0] CTRL_START = 32'h4;
  localparam logic [`DS_DATA_W-1:0] CTRL_KILL  = 32'h8;

  logic                  clk;
  logic                  arst_n;
  wb_req_t               wb_req;
  wb_rsp_t               wb_rsp;
  logic [`DS_DATA_W-1:0] exp_result;
  ds_status_t            exp_status;
  logic                  exp_status_en;
  logic [`DS_DATA_W-1:0] rd;  // Data of the last read
  int                    err_cnt;
  int                    chk_cnt;
  int                    timeout_cnt;
  bit                    aborted;  // Bus hung, remaining accesses skipped

  divsqrt_top dut_i (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  divsqrt_checker check_i (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .wb_req_i        (wb_req),
    .wb_rsp_i        (wb_rsp),
    .exp_result_i    (exp_result),
    .exp_status_i    (exp_status),
    .exp_status_en_i (exp_status_en),
    .err_cnt_o       (err_cnt),
    .chk_cnt_o       (chk_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // ------------------------------
  // Wishbone master
  // ------------------------------
  task automatic bus_access(input logic we, input wb_reg_e adr, input logic [31:0] wdat);
    int n;
    if (aborted) return;
    repeat ($urandom % 4) @(posedge clk);  // Random idle gap
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_rsp.ack && n < ACK_LIMIT);
    if (wb_rsp.ack) begin
      rd = wb_rsp.dat;
    end else begin
      $display("timeout: no ack for access to register %s", adr.name());
      timeout_cnt++;
      aborted = 1'b1;
    end
    @(posedge clk);
    wb_req <= '0;  // Drop stb after ack
  endtask

  // Operands, read back, then start
  task automatic start_op(input logic [31:0] op, fmt, a, b);
    bus_access(1'b1, REG_OPA, a);
    bus_access(1'b1, REG_OPB, b);
    bus_access(1'b0, REG_OPA, '0);
    bus_access(1'b0, REG_OPB, '0);
    bus_access(1'b1, REG_CTRL, CTRL_START | 32'({fmt[0], op[0]}));
  endtask

  task automatic read_status(input ds_status_t st);
    exp_status    = st;
    exp_status_en = 1'b1;
    bus_access(1'b0, REG_STATUS, '0);
    exp_status_en = 1'b0;
  endtask

  // Kind 0 plain, 1 extra start while busy, 2 killed op first
  task automatic run_line(input logic [31:0] kind, op, fmt, a, b, res, dz);
    int polls;
    case (kind)
      32'd1: begin
        start_op(op, fmt, a, b);
        read_status('{div_zero: dz[0], done: 1'b0, busy: 1'b1});
        bus_access(1'b1, REG_OPA, ~a);  // Different operands
        bus_access(1'b1, REG_OPB, b + 32'd1);
        bus_access(1'b1, REG_CTRL, CTRL_START | 32'({fmt[0], op[0]}));  // Dropped
      end
      32'd2: begin
        start_op(32'd0, 32'd0, 32'hffff_ffff, 32'h3);  // Long divide to flush
        bus_access(1'b1, REG_CTRL, CTRL_KILL);
        read_status('0);  // Flushed, done low
        start_op(op, fmt, a, b);
      end
      default: start_op(op, fmt, a, b);
    endcase
    polls = 0;
    rd    = '0;
    while (!aborted && !rd[1] && polls < POLL_LIMIT) begin
      bus_access(1'b0, REG_STATUS, '0);
      polls++;
    end
    if (!aborted && !rd[1]) begin
      $display("timeout: done still low after %0d STATUS reads", polls);
      timeout_cnt++;
      aborted = 1'b1;
    end
    exp_result = res;
    read_status('{div_zero: dz[0], done: 1'b1, busy: 1'b0});
    bus_access(1'b0, REG_RESULT, '0);
  endtask

  // ------------------------------
  // Stimulus file and summary
  // ------------------------------
  initial begin
    string       line;
    logic [31:0] kind, op, fmt, a, b, res, dz;
    int          fd;
    int          n_ops;
    wb_req        = '0;
    arst_n        = 1'b0;
    exp_result    = '0;
    exp_status    = '0;
    exp_status_en = 1'b0;
    rd            = '0;
    timeout_cnt   = 0;
    aborted       = 1'b0;
    n_ops         = 0;
    void'($urandom(32'h24e8_6b5c));
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    fd = $fopen("tb/divsqrt_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      aborted = 1'b1;
    end else begin
      while (!aborted && $fgets(line, fd) > 0) begin
        if ($sscanf(line, "%h %h %h %h %h %h %h", kind, op, fmt, a, b, res, dz) == 7) begin
          run_line(kind, op, fmt, a, b, res, dz);
          n_ops++;
        end  // Comment or blank line
      end
      $fclose(fd);
    end
    $display("operations %0d, checks %0d, errors %0d, timeouts %0d",
             n_ops, chk_cnt, err_cnt, timeout_cnt);
    if (!aborted && err_cnt == 0 && n_ops > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/divsqrt_checker.sv ====
// Wishbone monitor and result checker

`timescale 1ns/10ps
`include "divsqrt_params.svh"

module divsqrt_checker (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  wb_pkg::wb_req_t         wb_req_i,
  input  wb_pkg::wb_rsp_t         wb_rsp_i,
  input  logic [`DS_DATA_W-1:0]   exp_result_i,
  input  divsqrt_pkg::ds_status_t exp_status_i,
  input  logic                    exp_status_en_i,  // Compare STATUS reads
  output int                      err_cnt_o,
  output int                      chk_cnt_o
);

  import wb_pkg::*;
  import divsqrt_pkg::*;

  int                    err_cnt = 0;
  int                    chk_cnt = 0;
  logic                  access;
  logic                  acked_q = 1'b0;  // Ack already seen in this cycle
  wb_reg_e               adr;
  ds_status_t            st;
  logic [`DS_DATA_W-1:0] opa_seen;  // Last data written to OPA
  logic [`DS_DATA_W-1:0] opb_seen;

  assign access    = wb_req_i.cyc & wb_req_i.stb;
  assign adr       = wb_reg_e'(wb_req_i.adr);
  assign st        = ds_status_t'(wb_rsp_i.dat[2:0]);
  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    err_cnt++;
    $display("failure at %0t: %s", $time, what);
  endtask

  // Sampled mid-cycle, away from both drive edges
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (wb_rsp_i.ack && !access) report_failure("ack raised with no open bus cycle");
      if (!access) begin
        acked_q <= 1'b0;
      end else if (wb_rsp_i.ack) begin
        if (acked_q) report_failure("second ack within one bus cycle");
        acked_q <= 1'b1;
        if (wb_req_i.we) begin
          if (adr == REG_OPA) opa_seen <= wb_req_i.dat;
          if (adr == REG_OPB) opb_seen <= wb_req_i.dat;
        end else begin
          case (adr)
            REG_OPA:    compare("wb_rsp_o.dat OPA", wb_rsp_i.dat, opa_seen);
            REG_OPB:    compare("wb_rsp_o.dat OPB", wb_rsp_i.dat, opb_seen);
            REG_RESULT: compare("wb_rsp_o.dat RESULT", wb_rsp_i.dat, exp_result_i);
            REG_STATUS: begin
              if (st.busy && st.done) report_failure("STATUS shows busy and done together");
              if (exp_status_en_i) begin
                compare("wb_rsp_o.dat STATUS", wb_rsp_i.dat,
                        {{(`DS_DATA_W-3){1'b0}}, exp_status_i});
              end
            end
            default: ;  // CTRL not checked
          endcase
        end
      end
    end
  end

endmodule

// ==== hdl/divsqrt_top.sv ====
// Divide and square-root unit with Wishbone access

`timescale 1ns/10ps
`include "divsqrt_params.svh"

module divsqrt_top (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  wb_pkg::wb_req_t wb_req_i,
  output wb_pkg::wb_rsp_t wb_rsp_o
);

  import divsqrt_pkg::*;

  ds_req_t               req;
  ds_status_t            status;  // Assembled from FSM and datapath
  logic                  start;
  logic                  kill;
  logic                  load;
  logic                  step;
  logic                  last;
  logic [`DS_DATA_W-1:0] result;

  // Bus slave and registers
  divsqrt_wb_regs regs_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .req_o    (req),
    .start_o  (start),
    .kill_o   (kill),
    .status_i (status),
    .result_i (result)
  );

  divsqrt_fsm fsm_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (start),
    .kill_i   (kill),
    .last_i   (last),
    .load_o   (load),
    .step_o   (step),
    .busy_o   (status.busy),
    .done_o   (status.done)
  );

  iter_counter cnt_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .load_i   (load),
    .step_i   (step),
    .req_i    (req),
    .last_o   (last)
  );

  divsqrt_datapath dp_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .load_i     (load),
    .step_i     (step),
    .req_i      (req),
    .result_o   (result),
    .div_zero_o (status.div_zero)
  );

endmodule

// ==== hdl/divsqrt_datapath.sv ====
// Restoring divide and square-root datapath

`timescale 1ns/10ps
`include "divsqrt_params.svh"

module divsqrt_datapath (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  load_i,
  input  logic                  step_i,
  input  divsqrt_pkg::ds_req_t  req_i,
  output logic [`DS_DATA_W-1:0] result_o,
  output logic                  div_zero_o
);

  import divsqrt_pkg::*;

  localparam int W      = `DS_DATA_W;
  localparam int HALF_W = `DS_DATA_W / 2;

  ds_op_e       op_q;
  ds_fmt_e      fmt_q;
  logic         dz_q;    // Divide by zero seen at load
  logic [W-1:0] a_in;    // Operands cut to the format
  logic [W-1:0] b_in;
  logic [W-1:0] b_q;
  logic [W-1:0] src_q;   // Dividend or radicand, consumed MSB first
  logic [W-1:0] rem_q;   // Partial remainder
  logic [W-1:0] acc_q;   // Quotient or root bits
  logic [W:0]   part;    // Remainder with next bits shifted in
  logic [W:0]   trial;   // Value to subtract
  logic [W+1:0] diff;
  logic         ge;      // Subtract fits

  // ------------------------------
  // Operand selection
  // ------------------------------
  always_comb begin
    a_in = req_i.a;
    b_in = req_i.b;
    if (req_i.fmt == FMT_W16) begin
      a_in = {req_i.a[HALF_W-1:0], {HALF_W{1'b0}}};  // Left aligned
      b_in = {{HALF_W{1'b0}}, req_i.b[HALF_W-1:0]};
    end
  end

  // ------------------------------
  // One iteration
  // ------------------------------
  always_comb begin
    if (op_q == OP_DIV) begin
      part  = {rem_q, src_q[W-1]};  // One dividend bit
      trial = {1'b0, b_q};
    end else begin
      part  = {rem_q[W-2:0], src_q[W-1:W-2]};  // Two radicand bits
      trial = {acc_q[W-2:0], 2'b01};  // 4 * root + 1
    end
    diff = {1'b0, part} - {1'b0, trial};
    ge   = ~diff[W+1];
  end

  // Op, format, flag and result bits
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_q  <= OP_DIV;
      fmt_q <= FMT_W32;
      dz_q  <= 1'b0;
      acc_q <= '0;
    end else if (load_i) begin
      op_q  <= req_i.op;
      fmt_q <= req_i.fmt;
      dz_q  <= (req_i.op == OP_DIV) && (b_in == '0);
      acc_q <= '0;
    end else if (step_i) begin
      acc_q <= {acc_q[W-2:0], ge};  // New bit at LSB
    end
  end

  // Working registers
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      src_q <= a_in;
      b_q   <= b_in;
      rem_q <= '0;
    end else if (step_i) begin
      src_q <= (op_q == OP_DIV) ? (src_q << 1) : (src_q << 2);
      rem_q <= ge ? diff[W-1:0] : part[W-1:0];  // Restore on a failed subtract
    end
  end

  // ------------------------------
  // Result shaping
  // ------------------------------
  always_comb begin
    result_o = dz_q ? '1 : acc_q;  // All ones quotient on divide by zero
    if (fmt_q == FMT_W16) result_o[W-1:HALF_W] = '1;  // Boxed
  end

  assign div_zero_o = dz_q;

endmodule

// ==== hdl/iter_counter.sv ====
// Iteration down counter

`timescale 1ns/10ps
`include "divsqrt_params.svh"

module iter_counter (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 load_i,
  input  logic                 step_i,
  input  divsqrt_pkg::ds_req_t req_i,
  output logic                 last_o
);

  import divsqrt_pkg::*;

  localparam int CNT_W = $clog2(`DS_DATA_W) + 1;

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] init_cnt;

  // One step per result bit
  always_comb begin
    init_cnt = CNT_W'(`DS_DATA_W);
    if (req_i.fmt == FMT_W16) init_cnt = init_cnt >> 1;  // Half width
    if (req_i.op == OP_SQRT) init_cnt = init_cnt >> 1;   // Root has half the bits
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= init_cnt;
    end else if (step_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign last_o = (cnt_q == CNT_W'(1));

  // FSM must stop stepping once the count is spent
  a_no_step_at_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    step_i |-> (cnt_q != '0));

endmodule

// ==== hdl/divsqrt_fsm.sv ====
// Issue and iteration control

`timescale 1ns/10ps

module divsqrt_fsm (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic start_i,
  input  logic kill_i,
  input  logic last_i,   // Final iteration this cycle
  output logic load_o,
  output logic step_o,
  output logic busy_o,
  output logic done_o
);

  import divsqrt_pkg::*;

  ds_state_e state_q;
  ds_state_e state_d;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE, HOLD: begin
        if (start_i) state_d = BUSY;  // New op replaces held result
      end
      BUSY: begin
        if (kill_i) begin
          state_d = IDLE;  // Flush, done stays low
        end else if (last_i) begin
          state_d = HOLD;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Starts while busy are dropped here
  assign load_o = start_i & (state_q != BUSY);
  assign step_o = (state_q == BUSY) & ~kill_i;
  assign busy_o = (state_q == BUSY);
  assign done_o = (state_q == HOLD);

  // A fresh run never begins on its final step
  a_load_then_full_count: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    load_o |=> !last_i);

endmodule

// ==== hdl/divsqrt_wb_regs.sv ====
// Wishbone register block

`timescale 1ns/10ps
`include "divsqrt_params.svh"

module divsqrt_wb_regs (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  wb_pkg::wb_req_t         wb_req_i,
  output wb_pkg::wb_rsp_t         wb_rsp_o,
  output divsqrt_pkg::ds_req_t    req_o,
  output logic                    start_o,
  output logic                    kill_o,
  input  divsqrt_pkg::ds_status_t status_i,
  input  logic [`DS_DATA_W-1:0]   result_i
);

  import wb_pkg::*;
  import divsqrt_pkg::*;

  logic                  access;    // Cycle in progress
  logic                  wr_en;     // Write commits in the ack cycle
  logic                  ctrl_wr;
  wb_reg_e               adr;
  logic                  ack_q;
  logic [`DS_DATA_W-1:0] rd_mux;
  logic [`DS_DATA_W-1:0] rd_dat_q;
  logic [`DS_DATA_W-1:0] opa_q;
  logic [`DS_DATA_W-1:0] opb_q;
  ds_op_e                op_q;
  ds_fmt_e               fmt_q;
  logic                  start_q;
  logic                  kill_q;

  // ------------------------------
  // Bus decode
  // ------------------------------
  assign access  = wb_req_i.cyc & wb_req_i.stb;
  assign adr     = wb_reg_e'(wb_req_i.adr);
  assign wr_en   = access & wb_req_i.we & ack_q;
  assign ctrl_wr = wr_en && (adr == REG_CTRL);

  // Read data, sampled when ack is raised
  always_comb begin
    case (adr)
      REG_OPA:    rd_mux = opa_q;
      REG_OPB:    rd_mux = opb_q;
      REG_CTRL:   rd_mux = {{(`DS_DATA_W-2){1'b0}}, fmt_q, op_q};  // Pulse bits read zero
      REG_STATUS: rd_mux = {{(`DS_DATA_W-3){1'b0}}, status_i};
      REG_RESULT: rd_mux = result_i;
      default:    rd_mux = '0;  // Unmapped
    endcase
  end

  // ------------------------------
  // Control registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      kill_q  <= 1'b0;
      op_q    <= OP_DIV;
      fmt_q   <= FMT_W32;
    end else begin
      ack_q   <= access & ~ack_q;  // Single cycle ack
      start_q <= ctrl_wr & wb_req_i.dat[2];  // Self-clearing
      kill_q  <= ctrl_wr & wb_req_i.dat[3];
      if (ctrl_wr) begin
        op_q  <= ds_op_e'(wb_req_i.dat[0]);
        fmt_q <= ds_fmt_e'(wb_req_i.dat[1]);
      end
    end
  end

  // Operands and read data
  always_ff @(posedge clk_i) begin
    if (access & ~ack_q) rd_dat_q <= rd_mux;
    if (wr_en && (adr == REG_OPA)) opa_q <= wb_req_i.dat;
    if (wr_en && (adr == REG_OPB)) opb_q <= wb_req_i.dat;
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rd_dat_q;

  // Request towards the core
  assign req_o.op  = op_q;
  assign req_o.fmt = fmt_q;
  assign req_o.a   = opa_q;
  assign req_o.b   = opb_q;
  assign start_o   = start_q;
  assign kill_o    = kill_q;

  // Ack only while the master holds the cycle open
  a_ack_needs_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb));

endmodule

// ==== hdl/wb_pkg.sv ====
// Wishbone classic bundle types

`include "divsqrt_params.svh"

package wb_pkg;

  // Master to slave
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`DS_ADR_W-1:0]  adr;  // Word address
    logic [`DS_DATA_W-1:0] dat;  // Write data
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                  ack;
    logic [`DS_DATA_W-1:0] dat;  // Read data, valid with ack
  } wb_rsp_t;

  // Register map
  typedef enum logic [`DS_ADR_W-1:0] {
    REG_OPA    = `DS_REG_OPA,
    REG_OPB    = `DS_REG_OPB,
    REG_CTRL   = `DS_REG_CTRL,
    REG_STATUS = `DS_REG_STATUS,  // Read only
    REG_RESULT = `DS_REG_RESULT   // Read only
  } wb_reg_e;

endpackage

// ==== hdl/divsqrt_pkg.sv ====
// Divide and square-root core types

`include "divsqrt_params.svh"

package divsqrt_pkg;

  // Operation select, CTRL bit 0
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } ds_op_e;

  // Format select, CTRL bit 1
  typedef enum logic {
    FMT_W32 = 1'b0,
    FMT_W16 = 1'b1  // Low half used, upper result half boxed with ones
  } ds_fmt_e;

  // Request captured on start
  typedef struct packed {
    ds_op_e                op;
    ds_fmt_e               fmt;
    logic [`DS_DATA_W-1:0] a;  // Dividend or radicand
    logic [`DS_DATA_W-1:0] b;  // Divisor
  } ds_req_t;

  // Core status as seen in STATUS
  typedef struct packed {
    logic div_zero;  // Bit 2
    logic done;      // Bit 1
    logic busy;      // Bit 0
  } ds_status_t;

  // Control FSM states
  typedef enum logic [1:0] {IDLE, BUSY, HOLD} ds_state_e;

endpackage

// ==== hdl/divsqrt_params.svh ====
// Divide and square-root unit parameters

`ifndef DIVSQRT_PARAMS_SVH
`define DIVSQRT_PARAMS_SVH

// Operand and result width
`define DS_DATA_W 32

// Word address width of the register map
`define DS_ADR_W 3

// Register word offsets
`define DS_REG_OPA    3'd0
`define DS_REG_OPB    3'd1
`define DS_REG_CTRL   3'd2
`define DS_REG_STATUS 3'd3
`define DS_REG_RESULT 3'd4

`endif
